// ==== kpu_pkg.sv ====
package kpu_pkg;

  // Datapath geometry
  localparam int word_width = 32;
  localparam int reg_count = 32;
  localparam int reg_idx_width = 5;
  localparam int op_width = 6;
  // Shift distance comes from the low bits of tmp1
  localparam int shamt_width = 5;

  // Instruction word layout, opcode sits at bit 0
  localparam int src0_lsb = 6;
  localparam int src1_lsb = 11;
  localparam int offset_lsb = 16;
  localparam int offset_width = 16;

  // Opcodes, any code not listed is illegal
  typedef enum logic [op_width-1:0] {
    OP_ADD = 6'h00,
    OP_SUB = 6'h01,
    OP_AND = 6'h02,
    OP_OR  = 6'h03,
    OP_XOR = 6'h04,
    OP_MOV = 6'h05,
    OP_LDI = 6'h06,
    OP_SHL = 6'h08,
    OP_SHR = 6'h09,
    OP_SRA = 6'h0a
  } kpu_op_e;

  // Sequencer phases
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_READ_A,
    PH_READ_B,
    PH_EXEC
  } phase_e;

  // Bus driver select
  typedef enum logic [2:0] {
    BUS_NONE,
    BUS_REG,
    BUS_OFFSET,
    BUS_MLU,
    BUS_SHIFTER
  } bus_src_e;

  // MLU operation plane
  typedef enum logic [2:0] {
    MLU_ADD,
    MLU_SUB,
    MLU_AND,
    MLU_OR,
    MLU_XOR,
    MLU_PASS_B
  } mlu_op_e;

  // Shifter operation plane
  typedef enum logic [1:0] {
    SH_LEFT,
    SH_RIGHT,
    SH_ARITH
  } shift_op_e;

endpackage

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [kpu_pkg::reg_idx_width-1:0] rd_idx,
  input  logic [kpu_pkg::reg_idx_width-1:0] wr_idx,
  input  logic                              we,
  input  logic [kpu_pkg::word_width-1:0]    wr_data,
  output logic [kpu_pkg::word_width-1:0]    rd_data
);
  import kpu_pkg::*;

  // Architectural registers
  logic [word_width-1:0] regs [reg_count];

  // Bus write port, whole array clears on reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Bus read port, no latency
  assign rd_data = regs[rd_idx];

  // Write index comes from the opcode word in the control unit
  wr_idx_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    we |-> !$isunknown(wr_idx)
  ) else $error("register write with unknown index");

endmodule

// ==== mlu.sv ====
`timescale 1ns/1ps

module mlu (
  input  logic [kpu_pkg::word_width-1:0] a,
  input  logic [kpu_pkg::word_width-1:0] b,
  input  kpu_pkg::mlu_op_e               op,
  output logic [kpu_pkg::word_width-1:0] y,
  output logic                           z,
  output logic                           c,
  output logic                           n
);
  import kpu_pkg::*;

  // Adder result with carry in the top bit
  logic [word_width:0] sum;
  // Second adder operand, inverted for subtract
  logic [word_width-1:0] b_add;
  logic                  c_in;

  // Subtract as a + ~b + 1
  always_comb begin
    if (op == MLU_SUB) begin
      b_add = ~b;
      c_in  = 1'b1;
    end else begin
      b_add = b;
      c_in  = 1'b0;
    end
  end

  assign sum = {1'b0, a} + {1'b0, b_add} + {{word_width{1'b0}}, c_in};

  // Result select
  always_comb begin
    y = '0;
    c = 1'b0;
    case (op)
      MLU_ADD, MLU_SUB: begin
        y = sum[word_width-1:0];
        // Carry out, on subtract this reads as no borrow
        c = sum[word_width];
      end
      MLU_AND:    y = a & b;
      MLU_OR:     y = a | b;
      MLU_XOR:    y = a ^ b;
      MLU_PASS_B: y = b;
      default:    y = '0;
    endcase
  end

  // Zero and sign flags straight off the result
  assign z = (y == '0);
  assign n = y[word_width-1];

endmodule

// ==== shifter.sv ====
`timescale 1ns/1ps

module shifter (
  input  logic [kpu_pkg::word_width-1:0]  data,
  input  logic [kpu_pkg::shamt_width-1:0] amount,
  input  kpu_pkg::shift_op_e              op,
  output logic [kpu_pkg::word_width-1:0]  y
);
  import kpu_pkg::*;

  // Running value through the log stages
  logic [word_width-1:0] stage;

  // One stage per amount bit, stage i moves by 2**i
  always_comb begin
    stage = data;
    for (int i = 0; i < shamt_width; i++) begin
      if (amount[i]) begin
        case (op)
          SH_LEFT:  stage = stage << (1 << i);
          SH_RIGHT: stage = stage >> (1 << i);
          // Sign bit fills from the top
          SH_ARITH: stage = $signed(stage) >>> (1 << i);
          default:  stage = stage;
        endcase
      end
    end
  end

  assign y = stage;

endmodule

// ==== microcode_rom.sv ====
`timescale 1ns/1ps

module microcode_rom (
  input  kpu_pkg::kpu_op_e   op,
  output kpu_pkg::bus_src_e  b_src,
  output kpu_pkg::bus_src_e  exec_src,
  output kpu_pkg::mlu_op_e   mlu_op,
  output kpu_pkg::shift_op_e shift_op,
  output logic               writes_flags,
  output logic               illegal_op
);
  import kpu_pkg::*;

  // Fixed control planes per opcode
  always_comb begin
    // Defaults are a register operand into the MLU
    b_src        = BUS_REG;
    exec_src     = BUS_MLU;
    mlu_op       = MLU_ADD;
    shift_op     = SH_LEFT;
    writes_flags = 1'b1;
    illegal_op   = 1'b0;
    case (op)
      OP_ADD: mlu_op = MLU_ADD;
      OP_SUB: mlu_op = MLU_SUB;
      OP_AND: mlu_op = MLU_AND;
      OP_OR:  mlu_op = MLU_OR;
      OP_XOR: mlu_op = MLU_XOR;
      // Register copy through the B side
      OP_MOV: mlu_op = MLU_PASS_B;
      // Immediate from the offset field
      OP_LDI: begin
        b_src  = BUS_OFFSET;
        mlu_op = MLU_PASS_B;
      end
      // Shifts leave Z/C/N alone
      OP_SHL: begin
        exec_src     = BUS_SHIFTER;
        shift_op     = SH_LEFT;
        writes_flags = 1'b0;
      end
      OP_SHR: begin
        exec_src     = BUS_SHIFTER;
        shift_op     = SH_RIGHT;
        writes_flags = 1'b0;
      end
      OP_SRA: begin
        exec_src     = BUS_SHIFTER;
        shift_op     = SH_ARITH;
        writes_flags = 1'b0;
      end
      default: begin
        // Unlisted code, sequence still runs but nothing commits
        writes_flags = 1'b0;
        illegal_op   = 1'b1;
      end
    endcase
  end

endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              instr_valid,
  input  logic [kpu_pkg::word_width-1:0]    instr,
  output kpu_pkg::kpu_op_e                  op,
  input  kpu_pkg::bus_src_e                 b_src,
  input  kpu_pkg::bus_src_e                 exec_src,
  input  kpu_pkg::mlu_op_e                  mlu_op_in,
  input  kpu_pkg::shift_op_e                shift_op_in,
  input  logic                              writes_flags,
  input  logic                              illegal_op,
  output kpu_pkg::bus_src_e                 bus_src,
  output logic [kpu_pkg::reg_idx_width-1:0] rd_idx,
  output logic [kpu_pkg::reg_idx_width-1:0] wr_idx,
  output logic [kpu_pkg::word_width-1:0]    offset,
  output kpu_pkg::mlu_op_e                  mlu_op,
  output kpu_pkg::shift_op_e                shift_op,
  output logic                              tmp0_en,
  output logic                              tmp1_en,
  output logic                              reg_we,
  output logic                              flags_en,
  output logic                              result_en,
  output logic                              busy,
  output logic                              done,
  output logic                              illegal
);
  import kpu_pkg::*;

  logic [word_width-1:0]    op_word;
  logic [reg_idx_width-1:0] src0;
  logic [reg_idx_width-1:0] src1;
  phase_e                   phase_q;
  logic                     accept;

  assign accept = instr_valid && !busy;

  // Opcode word register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_word <= '0;
    end else if (accept) begin
      op_word <= instr;
    end
  end

  // Field split
  assign op     = kpu_op_e'(op_word[op_width-1:0]);
  assign src0   = op_word[src0_lsb +: reg_idx_width];
  assign src1   = op_word[src1_lsb +: reg_idx_width];
  assign offset = {{(word_width - offset_width){op_word[word_width-1]}},
                   op_word[offset_lsb +: offset_width]};

  // Phase sequencer
  // Idle with busy set is the decode cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase_q <= PH_IDLE;
      busy    <= 1'b0;
      done    <= 1'b0;
      illegal <= 1'b0;
    end else begin
      done    <= 1'b0;
      illegal <= 1'b0;
      case (phase_q)
        PH_IDLE: begin
          if (busy) begin
            phase_q <= PH_READ_A;
          end else if (accept) begin
            busy <= 1'b1;
          end
        end
        PH_READ_A: phase_q <= PH_READ_B;
        PH_READ_B: phase_q <= PH_EXEC;
        PH_EXEC: begin
          // Writeback edge
          // Done follows for one cycle
          phase_q <= PH_IDLE;
          busy    <= 1'b0;
          done    <= 1'b1;
          illegal <= illegal_op;
        end
        default: phase_q <= PH_IDLE;
      endcase
    end
  end

  // Bus source and enables per phase
  always_comb begin
    bus_src   = BUS_NONE;
    rd_idx    = src0;
    tmp0_en   = 1'b0;
    tmp1_en   = 1'b0;
    reg_we    = 1'b0;
    flags_en  = 1'b0;
    result_en = 1'b0;
    case (phase_q)
      PH_READ_A: begin
        bus_src = BUS_REG;
        tmp0_en = 1'b1;
      end
      PH_READ_B: begin
        bus_src = b_src;
        rd_idx  = src1;
        tmp1_en = 1'b1;
      end
      PH_EXEC: begin
        bus_src   = exec_src;
        // Illegal codes commit nothing
        reg_we    = !illegal_op;
        result_en = !illegal_op;
        flags_en  = writes_flags && !illegal_op;
      end
      default: bus_src = BUS_NONE;
    endcase
  end

  // Result always returns to src0
  assign wr_idx   = src0;
  assign mlu_op   = mlu_op_in;
  assign shift_op = shift_op_in;

  done_single: assert property (
    @(posedge clk) disable iff (!arst_n)
    done |=> !done
  ) else $error("done held for two cycles");

  // Exec slot sits four edges after the accept edge
  we_in_exec: assert property (
    @(posedge clk) disable iff (!arst_n)
    reg_we |-> $past(accept, 4)
  ) else $error("register write outside exec phase");

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps

module datapath (
  input  logic                              clk,
  input  logic                              arst_n,
  input  kpu_pkg::bus_src_e                 bus_src,
  input  logic [kpu_pkg::reg_idx_width-1:0] rd_idx,
  input  logic [kpu_pkg::reg_idx_width-1:0] wr_idx,
  input  logic [kpu_pkg::word_width-1:0]    offset,
  input  kpu_pkg::mlu_op_e                  mlu_op,
  input  kpu_pkg::shift_op_e                shift_op,
  input  logic                              tmp0_en,
  input  logic                              tmp1_en,
  input  logic                              reg_we,
  input  logic                              flags_en,
  input  logic                              result_en,
  output logic [kpu_pkg::word_width-1:0]    result,
  output logic [kpu_pkg::reg_idx_width-1:0] result_reg,
  output logic                              flag_z,
  output logic                              flag_c,
  output logic                              flag_n
);
  import kpu_pkg::*;

  // Shared bus and its drivers
  logic [word_width-1:0] bus;
  logic [word_width-1:0] reg_out;
  logic [word_width-1:0] mlu_out;
  logic [word_width-1:0] shifter_out;
  // Scratch registers, not visible to code
  logic [word_width-1:0] tmp0;
  logic [word_width-1:0] tmp1;
  logic mlu_z, mlu_c, mlu_n;

  register_file regs0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .rd_idx  (rd_idx),
    .wr_idx  (wr_idx),
    .we      (reg_we),
    .wr_data (bus),
    .rd_data (reg_out)
  );

  mlu mlu0 (.a(tmp0), .b(tmp1), .op(mlu_op), .y(mlu_out), .z(mlu_z), .c(mlu_c), .n(mlu_n));

  // Shift tmp0 by tmp1
  shifter shifter0 (
    .data   (tmp0),
    .amount (tmp1[shamt_width-1:0]),
    .op     (shift_op),
    .y      (shifter_out)
  );

  // One-hot bus mux
  always_comb begin
    case (bus_src)
      BUS_REG:     bus = reg_out;
      BUS_OFFSET:  bus = offset;
      BUS_MLU:     bus = mlu_out;
      BUS_SHIFTER: bus = shifter_out;
      default:     bus = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (tmp0_en) begin
      tmp0 <= bus;
    end
    if (tmp1_en) begin
      tmp1 <= bus;
    end
  end

  // Flags and the reported writeback
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flag_z     <= 1'b0;
      flag_c     <= 1'b0;
      flag_n     <= 1'b0;
      result     <= '0;
      result_reg <= '0;
    end else begin
      if (flags_en) begin
        flag_z <= mlu_z;
        flag_c <= mlu_c;
        flag_n <= mlu_n;
      end
      if (result_en) begin
        result     <= bus;
        result_reg <= wr_idx;
      end
    end
  end

  // Every latch needs a live bus driver
  bus_driven: assert property (
    @(posedge clk) disable iff (!arst_n)
    (tmp0_en || tmp1_en || reg_we || flags_en || result_en) |-> bus_src != BUS_NONE
  ) else $error("bus latched with no driver");

endmodule

// ==== kpu.sv ====
`timescale 1ns/1ps

module kpu (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              instr_valid,
  input  logic [kpu_pkg::word_width-1:0]    instr,
  output logic                              busy,
  output logic                              done,
  output logic                              illegal,
  output logic [kpu_pkg::word_width-1:0]    result,
  output logic [kpu_pkg::reg_idx_width-1:0] result_reg,
  output logic                              flag_z,
  output logic                              flag_c,
  output logic                              flag_n
);
  import kpu_pkg::*;

  // Opcode and microcode planes
  kpu_op_e   op;
  bus_src_e  b_src;
  bus_src_e  exec_src;
  mlu_op_e   ucode_mlu_op;
  shift_op_e ucode_shift_op;
  logic      writes_flags;
  logic      illegal_op;

  // Control unit to datapath
  bus_src_e                 bus_src;
  logic [reg_idx_width-1:0] rd_idx;
  logic [reg_idx_width-1:0] wr_idx;
  logic [word_width-1:0]    offset;
  mlu_op_e                  mlu_op;
  shift_op_e                shift_op;
  logic tmp0_en, tmp1_en, reg_we, flags_en, result_en;

  control_unit ctrl0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .op           (op),
    .b_src        (b_src),
    .exec_src     (exec_src),
    .mlu_op_in    (ucode_mlu_op),
    .shift_op_in  (ucode_shift_op),
    .writes_flags (writes_flags),
    .illegal_op   (illegal_op),
    .bus_src      (bus_src),
    .rd_idx       (rd_idx),
    .wr_idx       (wr_idx),
    .offset       (offset),
    .mlu_op       (mlu_op),
    .shift_op     (shift_op),
    .tmp0_en      (tmp0_en),
    .tmp1_en      (tmp1_en),
    .reg_we       (reg_we),
    .flags_en     (flags_en),
    .result_en    (result_en),
    .busy         (busy),
    .done         (done),
    .illegal      (illegal)
  );

  microcode_rom ucode0 (
    .op           (op),
    .b_src        (b_src),
    .exec_src     (exec_src),
    .mlu_op       (ucode_mlu_op),
    .shift_op     (ucode_shift_op),
    .writes_flags (writes_flags),
    .illegal_op   (illegal_op)
  );

  datapath dp0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .bus_src    (bus_src),
    .rd_idx     (rd_idx),
    .wr_idx     (wr_idx),
    .offset     (offset),
    .mlu_op     (mlu_op),
    .shift_op   (shift_op),
    .tmp0_en    (tmp0_en),
    .tmp1_en    (tmp1_en),
    .reg_we     (reg_we),
    .flags_en   (flags_en),
    .result_en  (result_en),
    .result     (result),
    .result_reg (result_reg),
    .flag_z     (flag_z),
    .flag_c     (flag_c),
    .flag_n     (flag_n)
  );

endmodule

// ==== kpu_tb.sv ====
`timescale 1ns/1ps

module kpu_tb;
  import kpu_pkg::*;

  // Run length, used by the watchdog
  localparam int n_directed = 32;
  localparam int n_random = 200;
  localparam int clk_period = 4;
  localparam int reset_cycles = 10;
  localparam int timeout_ns = (n_directed + n_random) * 8 * clk_period
                              + reset_cycles * clk_period;

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        busy;
  logic        done;
  logic        illegal;
  logic [31:0] result;
  logic [4:0]  result_reg;
  logic        flag_z;
  logic        flag_c;
  logic        flag_n;

  // Model state
  logic [31:0] model_regs [32];
  logic        model_z;
  logic        model_c;
  logic        model_n;
  logic [31:0] last_result;
  logic [4:0]  last_reg;

  // Expected responses in issue order
  logic [31:0] exp_value [$];
  logic [4:0]  exp_reg [$];
  logic [2:0]  exp_flags [$];
  logic        exp_illegal [$];
  int          exp_cycle [$];

  int          pending;
  int          errors;
  int          cycle_count;
  logic [15:0] lfsr_q;

  kpu dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .busy        (busy),
    .done        (done),
    .illegal     (illegal),
    .result      (result),
    .result_reg  (result_reg),
    .flag_z      (flag_z),
    .flag_c      (flag_c),
    .flag_n      (flag_n)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Edge counter for latency checks
  always @(posedge clk) cycle_count <= cycle_count + 1;

  // Expected {legal, writes flags, z, c, n, value} for one instruction
  function automatic logic [36:0] ref_exec(input logic [5:0] opc, input logic [31:0] a,
                                           input logic [31:0] b, input logic [31:0] imm);
    logic [32:0] wide;
    logic [31:0] y;
    logic        c;
    logic        legal;
    logic        wflags;
    y = '0;
    c = 1'b0;
    legal = 1'b1;
    wflags = 1'b1;
    case (opc)
      OP_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        y = wide[31:0];
        c = wide[32];
      end
      OP_SUB: begin
        y = a - b;
        // Carry means no borrow
        c = (a >= b);
      end
      OP_AND: y = a & b;
      OP_OR:  y = a | b;
      OP_XOR: y = a ^ b;
      OP_MOV: y = b;
      OP_LDI: y = imm;
      OP_SHL: begin
        y = a << b[4:0];
        wflags = 1'b0;
      end
      OP_SHR: begin
        y = a >> b[4:0];
        wflags = 1'b0;
      end
      OP_SRA: begin
        y = $signed(a) >>> b[4:0];
        wflags = 1'b0;
      end
      default: begin
        legal = 1'b0;
        wflags = 1'b0;
      end
    endcase
    return {legal, wflags, (y == 32'h0), c, y[31], y};
  endfunction

  function automatic logic [31:0] make_instr(input logic [5:0] opc, input logic [4:0] s0,
                                             input logic [4:0] s1, input logic [15:0] imm);
    return {imm, s1, s0, opc};
  endfunction

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits = {bits[30:0], lfsr_q[0]};
    end
  endtask

  // Weighted opcode set, last three are illegal
  function automatic logic [5:0] pick_opcode(input logic [3:0] sel);
    case (sel)
      4'd0, 4'd1: return OP_ADD;
      4'd2, 4'd3: return OP_SUB;
      4'd4:       return OP_AND;
      4'd5:       return OP_OR;
      4'd6:       return OP_XOR;
      4'd7:       return OP_MOV;
      4'd8, 4'd9: return OP_LDI;
      4'd10:      return OP_SHL;
      4'd11:      return OP_SHR;
      4'd12:      return OP_SRA;
      4'd13:      return 6'h07;
      4'd14:      return 6'h3f;
      default:    return 6'h1c;
    endcase
  endfunction

  task automatic random_instr(output logic [31:0] word);
    logic [31:0] sel;
    logic [31:0] s0;
    logic [31:0] s1;
    logic [31:0] imm;
    draw_bits(4, sel);
    draw_bits(5, s0);
    draw_bits(5, s1);
    draw_bits(16, imm);
    word = make_instr(pick_opcode(sel[3:0]), s0[4:0], s1[4:0], imm[15:0]);
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // Update the model on acceptance and queue the response
  task automatic model_accept(input logic [31:0] word, input int accept_cycle);
    logic [36:0] r;
    logic [4:0]  s0;
    s0 = word[10:6];
    r = ref_exec(word[5:0], model_regs[s0], model_regs[word[15:11]],
                 {{16{word[31]}}, word[31:16]});
    if (r[36]) begin
      model_regs[s0] = r[31:0];
      last_result = r[31:0];
      last_reg = s0;
    end
    if (r[35]) begin
      model_z = r[34];
      model_c = r[33];
      model_n = r[32];
    end
    exp_value.push_back(last_result);
    exp_reg.push_back(last_reg);
    exp_flags.push_back({model_z, model_c, model_n});
    exp_illegal.push_back(!r[36]);
    exp_cycle.push_back(accept_cycle);
    pending++;
  endtask

  // Starts and returns 0.5 ns after a rising edge
  task automatic issue(input logic [31:0] word, input logic poke);
    logic        taken;
    logic [31:0] junk;
    instr_valid = 1'b1;
    instr = word;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      if (!busy) begin
        taken = 1'b1;
      end
    end
    model_accept(word, cycle_count + 1);
    @(posedge clk);
    #0.5;
    instr_valid = 1'b0;
    if (poke) begin
      // Strobes while busy must be dropped
      for (int i = 0; i < 2; i++) begin
        random_instr(junk);
        instr_valid = 1'b1;
        instr = junk;
        @(posedge clk);
        #0.5;
      end
      instr_valid = 1'b0;
    end
  endtask

  // Compares every done against the queued response
  initial begin : compare_done
    logic [2:0] want_flags;
    forever begin
      @(negedge clk);
      if (done === 1'b1) begin
        if (pending == 0) begin
          errors++;
          $display("Done pulsed at %0t with no instruction in flight", $time);
          $display("Errors found");
          $fatal(1);
        end else begin
          want_flags = exp_flags.pop_front();
          check_value("done latency", cycle_count - exp_cycle.pop_front(), 4);
          check_value("result", result, exp_value.pop_front());
          check_value("result_reg", result_reg, exp_reg.pop_front());
          check_value("illegal", illegal, exp_illegal.pop_front());
          check_value("flags zcn", {flag_z, flag_c, flag_n}, want_flags);
          pending--;
        end
      end
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("Timeout after %0d ns, the core stopped completing instructions", timeout_ns);
    $display("Errors found");
    $fatal(1);
  end

  initial begin : stimulus
    logic [31:0] word;
    arst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    cycle_count = 0;
    pending = 0;
    errors = 0;
    lfsr_q = 16'd36;
    model_z = 1'b0;
    model_c = 1'b0;
    model_n = 1'b0;
    last_result = '0;
    last_reg = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    #0.5;
    arst_n = 1'b1;

    // Quiet outputs out of reset, registers read back zero
    @(negedge clk);
    check_value("busy", busy, 0);
    check_value("done", done, 0);
    check_value("illegal", illegal, 0);
    @(posedge clk);
    #0.5;
    issue(make_instr(OP_MOV, 5'd1, 5'd7, 16'h0), 1'b0);
    issue(make_instr(OP_MOV, 5'd31, 5'd0, 16'h0), 1'b0);
    issue(make_instr(OP_MOV, 5'd5, 5'd18, 16'h0), 1'b0);

    // Immediates then ALU with carry and borrow cases
    issue(make_instr(OP_LDI, 5'd1, 5'd0, 16'h1234), 1'b0);
    issue(make_instr(OP_LDI, 5'd2, 5'd0, 16'hfffe), 1'b0);
    issue(make_instr(OP_ADD, 5'd1, 5'd2, 16'h0), 1'b0);
    issue(make_instr(OP_LDI, 5'd3, 5'd0, 16'h0005), 1'b0);
    issue(make_instr(OP_LDI, 5'd4, 5'd0, 16'h0003), 1'b0);
    issue(make_instr(OP_SUB, 5'd3, 5'd4, 16'h0), 1'b0);
    issue(make_instr(OP_SUB, 5'd4, 5'd1, 16'h0), 1'b0);
    issue(make_instr(OP_SUB, 5'd3, 5'd3, 16'h0), 1'b0);
    issue(make_instr(OP_AND, 5'd1, 5'd2, 16'h0), 1'b0);
    issue(make_instr(OP_OR, 5'd4, 5'd2, 16'h0), 1'b0);
    issue(make_instr(OP_XOR, 5'd2, 5'd2, 16'h0), 1'b0);
    issue(make_instr(OP_LDI, 5'd5, 5'd0, 16'h8000), 1'b0);
    issue(make_instr(OP_ADD, 5'd5, 5'd5, 16'h0), 1'b0);

    // Shifts after a flag-setting subtract
    issue(make_instr(OP_LDI, 5'd6, 5'd0, 16'h8421), 1'b0);
    issue(make_instr(OP_LDI, 5'd7, 5'd0, 16'h0004), 1'b0);
    issue(make_instr(OP_LDI, 5'd8, 5'd0, 16'h001f), 1'b0);
    issue(make_instr(OP_LDI, 5'd11, 5'd0, 16'h0021), 1'b0);
    issue(make_instr(OP_SUB, 5'd10, 5'd7, 16'h0), 1'b0);
    issue(make_instr(OP_SHL, 5'd6, 5'd7, 16'h0), 1'b0);
    issue(make_instr(OP_SRA, 5'd6, 5'd8, 16'h0), 1'b0);
    issue(make_instr(OP_SHR, 5'd6, 5'd7, 16'h0), 1'b0);
    // Amount 33 wraps to 1
    issue(make_instr(OP_SHR, 5'd6, 5'd11, 16'h0), 1'b0);
    issue(make_instr(OP_SHL, 5'd7, 5'd8, 16'h0), 1'b0);

    // Strobes while busy
    issue(make_instr(OP_ADD, 5'd1, 5'd2, 16'h0), 1'b1);
    issue(make_instr(OP_XOR, 5'd3, 5'd1, 16'h0), 1'b1);

    // Illegal codes, then read back what they must not touch
    issue(make_instr(6'h07, 5'd1, 5'd2, 16'h5555), 1'b0);
    issue(make_instr(6'h3f, 5'd3, 5'd6, 16'haaaa), 1'b0);
    issue(make_instr(6'h20, 5'd1, 5'd1, 16'h0001), 1'b0);
    issue(make_instr(OP_MOV, 5'd12, 5'd1, 16'h0), 1'b0);

    // Back to back random traffic
    for (int n = 0; n < n_random; n++) begin
      random_instr(word);
      issue(word, 1'b0);
    end

    wait (pending == 0);
    repeat (2) @(posedge clk);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
kpu_pkg.sv
register_file.sv
mlu.sv
shifter.sv
microcode_rom.sv
control_unit.sv
datapath.sv
kpu.sv
kpu_tb.sv

// ==== Bender.yml ====
package:
  name: kpu

sources:
  - kpu_pkg.sv
  - register_file.sv
  - mlu.sv
  - shifter.sv
  - microcode_rom.sv
  - control_unit.sv
  - datapath.sv
  - kpu.sv
  - target: test
    files:
      - kpu_tb.sv
